/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_id_stage -f vlog.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "^Everything OK$" sim.log && echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* tb/id_ref_model.svh */
// Reference model functions: 32-bit decode, compressed decode and expected issue entry
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// Fields of a 32-bit instruction where ex.valid marks an illegal encoding for now
function automatic issue_entry_t decode_full(logic [31:0] i);
  issue_entry_t e;
  e = '0;
  case (i[6:0])
    OpLui, OpAuipc: begin
      e.fu      = FuAlu;
      e.rd      = i[11:7];
      e.imm     = {i[31:12], 12'b0};
      e.use_imm = 1'b1;
    end
    OpJal: begin
      e.fu      = FuCtrlFlow;
      e.rd      = i[11:7];
      e.imm     = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      e.use_imm = 1'b1;
    end
    // I-type formats
    OpJalr, OpLoad, OpOpImm: begin
      e.rd      = i[11:7];
      e.rs1     = i[19:15];
      e.imm     = {{20{i[31]}}, i[31:20]};
      e.use_imm = 1'b1;
      if (i[6:0] == OpJalr) begin
        e.fu = FuCtrlFlow;
      end else if (i[6:0] == OpLoad) begin
        e.fu       = FuLoad;
        e.ex.valid = !(i[14:12] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
      end else begin
        e.fu = FuAlu;
      end
    end
    OpBranch: begin
      e.fu       = FuCtrlFlow;
      e.rs1      = i[19:15];
      e.rs2      = i[24:20];
      e.imm      = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      e.ex.valid = (i[14:12] == 3'd2) || (i[14:12] == 3'd3);
    end
    OpStore: begin
      e.fu       = FuStore;
      e.rs1      = i[19:15];
      e.rs2      = i[24:20];
      e.imm      = {{20{i[31]}}, i[31:25], i[11:7]};
      e.use_imm  = 1'b1;
      e.ex.valid = i[14:12] > 3'd2;
    end
    OpOp: begin
      e.fu       = FuAlu;
      e.rd       = i[11:7];
      e.rs1      = i[19:15];
      e.rs2      = i[24:20];
      e.ex.valid = !(i[31:25] inside {7'b0000000, 7'b0100000});
    end
    default: e.ex.valid = 1'b1;
  endcase
  return e;
endfunction

// Fields of a compressed instruction read straight from the 16-bit formats
function automatic issue_entry_t decode_compressed(logic [15:0] c);
  issue_entry_t e;
  e = '0;
  // Unsupported until one of the forms below matches
  e.ex.valid = 1'b1;
  if (EnableRvc) begin
    case ({c[1:0], c[15:13]})
      {Q0, C3Lw}, {Q0, C3Sw}: begin
        e.rs1      = {2'b01, c[9:7]};
        e.imm      = {25'b0, c[5], c[12:10], c[6], 2'b00};
        e.use_imm  = 1'b1;
        e.ex.valid = 1'b0;
        if (c[15]) begin
          e.fu  = FuStore;
          e.rs2 = {2'b01, c[4:2]};
        end else begin
          e.fu = FuLoad;
          e.rd = {2'b01, c[4:2]};
        end
      end
      {Q1, C3Addi}, {Q1, C3Li}: begin
        e.fu       = FuAlu;
        e.rd       = c[11:7];
        // C.LI adds to x0
        e.rs1      = c[14] ? 5'd0 : c[11:7];
        e.imm      = {{26{c[12]}}, c[12], c[6:2]};
        e.use_imm  = 1'b1;
        e.ex.valid = 1'b0;
      end
      {Q1, C3J}: begin
        e.fu       = FuCtrlFlow;
        e.imm      = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        e.use_imm  = 1'b1;
        e.ex.valid = 1'b0;
      end
      {Q1, C3Beqz}, {Q1, C3Bnez}: begin
        e.fu       = FuCtrlFlow;
        e.rs1      = {2'b01, c[9:7]};
        e.imm      = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        e.ex.valid = 1'b0;
      end
      {Q2, C3MvAdd}: begin
        if (c[6:2] != 5'd0) begin
          e.fu       = FuAlu;
          e.rd       = c[11:7];
          e.rs1      = c[12] ? c[11:7] : 5'd0;
          e.rs2      = c[6:2];
          e.ex.valid = 1'b0;
        end
      end
      default: ;
    endcase
  end
  return e;
endfunction

// Expected issue entry for one consumed fetch
function automatic issue_entry_t expected_entry(fetch_entry_t f);
  issue_entry_t e;
  if (f.instr[1:0] != 2'b11) begin
    e               = decode_compressed(f.instr[15:0]);
    e.is_compressed = 1'b1;
    e.orig_instr    = {16'b0, f.instr[15:0]};
  end else begin
    e            = decode_full(f.instr);
    e.orig_instr = f.instr;
  end
  e.pc           = f.pc;
  e.is_ctrl_flow = (e.fu == FuCtrlFlow);
  // Fetch fault outranks an illegal encoding
  if (f.fetch_fault) begin
    e.ex = '{valid: 1'b1, cause: CauseFetchFault, tval: f.pc};
  end else if (e.ex.valid) begin
    e.ex = '{valid: 1'b1, cause: CauseIllegal, tval: e.orig_instr};
  end
  if (e.ex.valid) begin
    e.fu           = FuNone;
    e.rd           = '0;
    e.rs1          = '0;
    e.rs2          = '0;
    e.imm          = '0;
    e.is_ctrl_flow = 1'b0;
  end
  return e;
endfunction

`endif

/* tb/tb_id_stage.sv */
// Decode stage testbench: clock, reset, random instructions, model queue, checks and report
module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;
  import id_pkg::*;

  localparam bit EnableRvc = 1'b1;
  localparam int NumInstr  = 3000;
  // Near 2.4 cycles per instruction expected, so this leaves a wide margin
  localparam int MaxCycles = NumInstr * 20 / 3;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  fetch_entry_t fetch_entry_i;
  logic         fetch_valid_i;
  logic         fetch_ready_o;
  issue_entry_t issue_entry_o;
  logic         issue_valid_o;
  logic         issue_ack_i;

  // Entries the register should hold with the oldest first
  issue_entry_t exp_q[$];
  int           sent;
  int           cycles;
  int           mismatches;
  int           other_errors;

  `include "id_ref_model.svh"

  id_stage #(
    .EnableRvc(EnableRvc)
  ) dut_i (
    .*
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // Stimulus
  // --------------------
  function automatic logic [15:0] random_compressed();
    logic [15:0] c;
    c = 16'($urandom);
    case ($urandom % 8)
      0: {c[15:13], c[1:0]} = {C3Lw, Q0};
      1: {c[15:13], c[1:0]} = {C3Sw, Q0};
      2: {c[15:13], c[1:0]} = {C3Addi, Q1};
      3: {c[15:13], c[1:0]} = {C3Li, Q1};
      4: {c[15:13], c[1:0]} = {C3J, Q1};
      5: {c[15:13], c[1:0]} = {C3Beqz, Q1};
      6: {c[15:13], c[1:0]} = {C3Bnez, Q1};
      default: begin
        {c[15:13], c[1:0]} = {C3MvAdd, Q2};
        // A zero rs2 would select C.JR or C.JALR
        if (c[6:2] == 5'd0) begin
          c[6:2] = 5'd1;
        end
      end
    endcase
    return c;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    r = $urandom;
    case ($urandom % 12)
      0: r[6:0] = ($urandom % 2 == 0) ? OpLui : OpAuipc;
      1: r[6:0] = OpJal;
      2: begin
        r[6:0]   = OpJalr;
        r[14:12] = 3'd0;
      end
      3: r[6:0] = OpBranch;
      4: r[6:0] = OpLoad;
      5: r[6:0] = OpStore;
      6: r[6:0] = OpOpImm;
      7: begin
        r[6:0] = OpOp;
        case ($urandom % 3)
          0: r[31:25] = 7'b0000000;
          1: r[31:25] = 7'b0100000;
          default: ;
        endcase
      end
      // Random major opcode that is mostly illegal
      8: r[1:0] = 2'b11;
      9, 10: r[15:0] = random_compressed();
      default: begin
        r[1:0] = 2'($urandom % 3);
        if ($urandom % 8 == 0) begin
          r[15:0] = '0;
        end
      end
    endcase
    return r;
  endfunction

  task automatic drive_stimulus();
    fetch_entry_t f;
    f.pc          = $urandom;
    f.pc[0]       = 1'b0;
    f.instr       = random_instr();
    f.fetch_fault = ($urandom % 16) == 0;
    fetch_entry_i <= f;
    fetch_valid_i <= ($urandom % 4) != 0;
    // Acknowledge only while the model holds an entry
    issue_ack_i   <= (exp_q.size() != 0) && ($urandom % 2 == 0);
    flush_i       <= ($urandom % 50) == 0;
  endtask

  // --------------------
  // Checks and model
  // --------------------
  task automatic check_cycle();
    logic exp_valid;
    logic exp_ready;
    cycles++;
    exp_valid = (exp_q.size() != 0);
    exp_ready = fetch_valid_i && (!exp_valid || issue_ack_i);
    assert (issue_valid_o === exp_valid) else begin
      $display("mismatch at %0d ns: issue_valid_o got %b expected %b",
               $time, issue_valid_o, exp_valid);
      mismatches++;
    end
    assert (fetch_ready_o === exp_ready) else begin
      $display("mismatch at %0d ns: fetch_ready_o got %b expected %b",
               $time, fetch_ready_o, exp_ready);
      mismatches++;
    end
    if (exp_valid) begin
      // Checked in every held cycle, so a held entry may not change
      assert (issue_entry_o === exp_q[0]) else begin
        $display("mismatch at %0d ns: issue_entry_o got %h expected %h",
                 $time, issue_entry_o, exp_q[0]);
        mismatches++;
      end
      if (issue_ack_i) begin
        void'(exp_q.pop_front());
      end
    end
    if (exp_ready) begin
      exp_q.push_back(expected_entry(fetch_entry_i));
      sent++;
    end
    // Drops the entry taken in this cycle too
    if (flush_i) begin
      exp_q.delete();
    end
  endtask

  initial begin
    void'($urandom(32'h71a4));
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_entry_i = '0;
    fetch_valid_i = 1'b0;
    issue_ack_i   = 1'b0;
    sent          = 0;
    cycles        = 0;
    mismatches    = 0;
    other_errors  = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (sent < NumInstr && cycles < MaxCycles) begin
      @(negedge clk_i);
      check_cycle();
      @(posedge clk_i);
      drive_stimulus();
    end
    if (sent < NumInstr) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions were consumed",
               cycles, sent, NumInstr);
      other_errors++;
    end
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog/id_pkg.sv */
// Decode stage types: fetch entry, exception record, functional unit and issue entry
package id_pkg;

  // --------------------
  // Fetch side
  // --------------------
  typedef struct packed {
    logic [isa_pkg::XLen-1:0]       pc;
    logic [isa_pkg::InstrWidth-1:0] instr;
    logic                           fetch_fault;
  } fetch_entry_t;

  // --------------------
  // Exceptions
  // --------------------
  typedef struct packed {
    logic                           valid;
    logic [isa_pkg::CauseWidth-1:0] cause;
    logic [isa_pkg::XLen-1:0]       tval;
  } exception_t;

  // Functional unit that will execute the instruction
  typedef enum logic [2:0] {
    FuNone,
    FuAlu,
    FuCtrlFlow,
    FuLoad,
    FuStore
  } fu_t;

  // --------------------
  // Issue side
  // --------------------
  typedef struct packed {
    logic [isa_pkg::XLen-1:0]         pc;
    fu_t                              fu;
    logic [isa_pkg::RegAddrWidth-1:0] rd;
    logic [isa_pkg::RegAddrWidth-1:0] rs1;
    logic [isa_pkg::RegAddrWidth-1:0] rs2;
    logic [isa_pkg::XLen-1:0]         imm;
    logic                             use_imm;
    exception_t                       ex;
    logic                             is_compressed;
    logic                             is_ctrl_flow;
    // Fetched word with the upper half zero for a compressed instruction
    logic [isa_pkg::InstrWidth-1:0]   orig_instr;
  } issue_entry_t;

endpackage

/* verilog/id_stage.sv */
// Decode stage top: compressed expander, instruction decoder and issue register
module id_stage #(
  parameter bit EnableRvc = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Fetch handshake
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  // Issue handshake
  output id_pkg::issue_entry_t issue_entry_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ack_i
);
  import isa_pkg::*;
  import id_pkg::*;

  logic [InstrWidth-1:0] expanded_instr;
  logic                  rvc_illegal;
  logic                  rvc_is_compressed;
  issue_entry_t          decoded_entry;

  rvc_expander #(
    .EnableRvc(EnableRvc)
  ) i_rvc_expander (
    .instr_i        (fetch_entry_i.instr),
    .instr_o        (expanded_instr),
    .illegal_o      (rvc_illegal),
    .is_compressed_o(rvc_is_compressed)
  );

  // Decoder keeps only the low halfword of a compressed original
  instr_decoder i_instr_decoder (
    .pc_i           (fetch_entry_i.pc),
    .instr_i        (expanded_instr),
    .orig_instr_i   (fetch_entry_i.instr),
    .illegal_i      (rvc_illegal),
    .is_compressed_i(rvc_is_compressed),
    .fetch_fault_i  (fetch_entry_i.fetch_fault),
    .entry_o        (decoded_entry)
  );

  issue_register i_issue_register (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .entry_i      (decoded_entry),
    .fetch_valid_i(fetch_valid_i),
    .fetch_ready_o(fetch_ready_o),
    .ack_i        (issue_ack_i),
    .entry_o      (issue_entry_o),
    .valid_o      (issue_valid_o)
  );

endmodule

/* verilog/instr_decoder.sv */
// RV32I base decoder producing the issue entry with operands, immediate and exception
module instr_decoder (
  input  logic [isa_pkg::XLen-1:0]       pc_i,
  input  logic [isa_pkg::InstrWidth-1:0] instr_i,
  input  logic [isa_pkg::InstrWidth-1:0] orig_instr_i,
  input  logic                           illegal_i,
  input  logic                           is_compressed_i,
  input  logic                           fetch_fault_i,
  output id_pkg::issue_entry_t           entry_o
);
  import isa_pkg::*;
  import id_pkg::*;

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [XLen-1:0]         imm_i_type;
  logic [XLen-1:0]         imm_s_type;
  logic [XLen-1:0]         imm_b_type;
  logic [XLen-1:0]         imm_u_type;
  logic [XLen-1:0]         imm_j_type;
  logic [InstrWidth-1:0]   orig_instr;
  fu_t                     fu;
  logic [RegAddrWidth-1:0] rd, rs1, rs2;
  logic [XLen-1:0]         imm;
  logic                    use_imm;
  logic                    ctrl_flow;
  logic                    dec_illegal;
  exception_t              ex;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates of every format
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  assign orig_instr = is_compressed_i ? {{(InstrWidth-16){1'b0}}, orig_instr_i[15:0]}
                                      : orig_instr_i;

  // --------------------
  // Opcode decode
  // --------------------
  always_comb begin
    fu          = FuNone;
    rd          = '0;
    rs1         = '0;
    rs2         = '0;
    imm         = '0;
    use_imm     = 1'b0;
    ctrl_flow   = 1'b0;
    dec_illegal = 1'b0;

    unique case (opcode)
      OpLui, OpAuipc: begin
        fu      = FuAlu;
        rd      = instr_i[11:7];
        imm     = imm_u_type;
        use_imm = 1'b1;
      end
      OpJal: begin
        fu        = FuCtrlFlow;
        rd        = instr_i[11:7];
        imm       = imm_j_type;
        use_imm   = 1'b1;
        ctrl_flow = 1'b1;
      end
      OpJalr: begin
        fu        = FuCtrlFlow;
        rd        = instr_i[11:7];
        rs1       = instr_i[19:15];
        imm       = imm_i_type;
        use_imm   = 1'b1;
        ctrl_flow = 1'b1;
      end
      OpBranch: begin
        fu          = FuCtrlFlow;
        rs1         = instr_i[19:15];
        rs2         = instr_i[24:20];
        imm         = imm_b_type;
        ctrl_flow   = 1'b1;
        dec_illegal = (funct3 == 3'd2) || (funct3 == 3'd3);
      end
      OpLoad: begin
        fu          = FuLoad;
        rd          = instr_i[11:7];
        rs1         = instr_i[19:15];
        imm         = imm_i_type;
        use_imm     = 1'b1;
        dec_illegal = (funct3 == 3'd3) || (funct3 > 3'd5);
      end
      OpStore: begin
        fu          = FuStore;
        rs1         = instr_i[19:15];
        rs2         = instr_i[24:20];
        imm         = imm_s_type;
        use_imm     = 1'b1;
        dec_illegal = (funct3 > 3'd2);
      end
      OpOpImm: begin
        fu      = FuAlu;
        rd      = instr_i[11:7];
        rs1     = instr_i[19:15];
        imm     = imm_i_type;
        use_imm = 1'b1;
      end
      OpOp: begin
        fu          = FuAlu;
        rd          = instr_i[11:7];
        rs1         = instr_i[19:15];
        rs2         = instr_i[24:20];
        dec_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  // --------------------
  // Exception and output
  // --------------------
  always_comb begin
    ex = '0;
    // Fetch fault wins over an illegal encoding
    if (fetch_fault_i) begin
      ex = '{valid: 1'b1, cause: CauseFetchFault, tval: pc_i};
    end else if (illegal_i || dec_illegal) begin
      ex = '{valid: 1'b1, cause: CauseIllegal, tval: orig_instr};
    end

    entry_o.pc            = pc_i;
    entry_o.fu            = ex.valid ? FuNone : fu;
    entry_o.rd            = ex.valid ? '0 : rd;
    entry_o.rs1           = ex.valid ? '0 : rs1;
    entry_o.rs2           = ex.valid ? '0 : rs2;
    entry_o.imm           = ex.valid ? '0 : imm;
    entry_o.use_imm       = use_imm;
    entry_o.ex            = ex;
    entry_o.is_compressed = is_compressed_i;
    entry_o.is_ctrl_flow  = ctrl_flow && !ex.valid;
    entry_o.orig_instr    = orig_instr;
  end

endmodule

/* verilog/isa_pkg.sv */
// RV32I and RVC constants: widths, major opcodes, compressed quadrants and funct3, causes
package isa_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned InstrWidth   = 32;
  localparam int unsigned XLen         = 32;
  localparam int unsigned RegAddrWidth = 5;
  localparam int unsigned CauseWidth   = 5;

  // --------------------
  // Major opcodes
  // --------------------
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpOpImm  = 7'b0010011;
  localparam logic [6:0] OpOp     = 7'b0110011;

  // --------------------
  // Compressed encoding
  // --------------------
  // Quadrant 3 (2'b11) marks a full 32-bit instruction
  localparam logic [1:0] Q0 = 2'b00;
  localparam logic [1:0] Q1 = 2'b01;
  localparam logic [1:0] Q2 = 2'b10;

  // Quadrant 0
  localparam logic [2:0] C3Lw     = 3'b010;
  localparam logic [2:0] C3Sw     = 3'b110;
  // Quadrant 1
  localparam logic [2:0] C3Addi   = 3'b000;
  localparam logic [2:0] C3Li     = 3'b010;
  localparam logic [2:0] C3J      = 3'b101;
  localparam logic [2:0] C3Beqz   = 3'b110;
  localparam logic [2:0] C3Bnez   = 3'b111;
  // Quadrant 2 code shared by C.MV and C.ADD
  localparam logic [2:0] C3MvAdd  = 3'b100;

  // Exception causes
  localparam logic [CauseWidth-1:0] CauseFetchFault = 5'd1;
  localparam logic [CauseWidth-1:0] CauseIllegal    = 5'd2;

endpackage

/* verilog/issue_register.sv */
// One-entry register between decode and issue with fetch handshake, acknowledge and flush
module issue_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  id_pkg::issue_entry_t entry_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  logic                 ack_i,
  output id_pkg::issue_entry_t entry_o,
  output logic                 valid_o
);
  import id_pkg::*;

  logic         valid_d, valid_q;
  issue_entry_t entry_q;

  // Space now, or freed by the acknowledge in this cycle
  assign fetch_ready_o = fetch_valid_i && (!valid_q || ack_i);

  always_comb begin
    valid_d = valid_q;
    if (ack_i) begin
      valid_d = 1'b0;
    end
    if (fetch_ready_o) begin
      valid_d = 1'b1;
    end
    // Entry taken in a flush cycle is consumed but dropped
    if (flush_i) begin
      valid_d = 1'b0;
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      entry_q <= '0;
    end else begin
      valid_q <= valid_d;
      if (fetch_ready_o) begin
        entry_q <= entry_i;
      end
    end
  end

  assign entry_o = entry_q;
  assign valid_o = valid_q;

endmodule

/* verilog/rvc_expander.sv */
// Compressed instruction expander for C.LW, C.SW, C.ADDI, C.LI, C.J, C.BEQZ, C.BNEZ, C.MV, C.ADD
module rvc_expander #(
  parameter bit EnableRvc = 1'b1
) (
  input  logic [isa_pkg::InstrWidth-1:0] instr_i,
  output logic [isa_pkg::InstrWidth-1:0] instr_o,
  output logic                           illegal_o,
  output logic                           is_compressed_o
);
  import isa_pkg::*;

  logic [15:0] c;

  assign c               = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      // Anything not matched below stays illegal with a zero word
      instr_o   = '0;
      illegal_o = 1'b1;

      if (EnableRvc) begin
        unique case (c[1:0])
          // --------------------
          // Quadrant 0
          // --------------------
          Q0: begin
            unique case (c[15:13])
              C3Lw: begin
                // lw rd', uimm(rs1')
                instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                             2'b01, c[4:2], OpLoad};
                illegal_o = 1'b0;
              end
              C3Sw: begin
                // sw rs2', uimm(rs1')
                instr_o   = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                             c[11:10], c[6], 2'b00, OpStore};
                illegal_o = 1'b0;
              end
              default: ;
            endcase
          end
          // --------------------
          // Quadrant 1
          // --------------------
          Q1: begin
            unique case (c[15:13])
              C3Addi: begin
                instr_o   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], OpOpImm};
                illegal_o = 1'b0;
              end
              C3Li: begin
                // addi rd, x0, imm
                instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7], OpOpImm};
                illegal_o = 1'b0;
              end
              C3J: begin
                // jal x0, offset
                instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                             c[12], {8{c[12]}}, 5'b0, OpJal};
                illegal_o = 1'b0;
              end
              C3Beqz, C3Bnez: begin
                // beq/bne rs1', x0, offset
                // The low funct3 bit picks bne
                instr_o   = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00, c[13],
                             c[11:10], c[4:3], c[12], OpBranch};
                illegal_o = 1'b0;
              end
              default: ;
            endcase
          end
          // --------------------
          // Quadrant 2
          // --------------------
          Q2: begin
            // A zero rs2 selects the unsupported C.JR, C.JALR or C.EBREAK
            if (c[15:13] == C3MvAdd && c[6:2] != 5'b0) begin
              if (c[12]) begin
                // add rd, rd, rs2
                instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OpOp};
              end else begin
                // add rd, x0, rs2
                instr_o = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], OpOp};
              end
              illegal_o = 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* vlog.f */
+incdir+tb
verilog/isa_pkg.sv
verilog/id_pkg.sv
verilog/rvc_expander.sv
verilog/instr_decoder.sv
verilog/issue_register.sv
verilog/id_stage.sv
tb/tb_id_stage.sv
